// File: verilog/uart_tx_pkg.sv
`default_nettype none

package uart_tx_pkg;

    // Frame format
    localparam int DATA_WIDTH = 8;

    // Serializer bit counter, wide enough to count DATA_WIDTH bits
    localparam int CNT_WIDTH = 3;

    // Line select codes for the output multiplexer
    // Constant low for the start bit
    localparam logic [1:0] SEL_START = 2'b00;

    // Constant high, shared by the idle line and the stop bit
    localparam logic [1:0] SEL_IDLE_STOP = 2'b01;

    // Serial data bit from the shift register
    localparam logic [1:0] SEL_DATA = 2'b10;

    // Parity bit from the parity unit
    localparam logic [1:0] SEL_PARITY = 2'b11;

    // Parity type codes
    localparam logic PAR_EVEN = 1'b0;
    localparam logic PAR_ODD = 1'b1;

endpackage

`default_nettype wire

// File: verilog/uart_tx_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx_fsm
    import uart_tx_pkg::*;
(
    input  wire        CLK,
    input  wire        RST,
    input  wire        data_valid,
    input  wire        par_en,
    input  wire        ser_done,
    output logic [1:0] mux_sel,
    output logic       ser_en,
    output logic       busy
);

    // One-hot state encoding
    localparam logic [4:0] ST_IDLE = 5'b00001;
    localparam logic [4:0] ST_START = 5'b00010;
    localparam logic [4:0] ST_DATA = 5'b00100;
    localparam logic [4:0] ST_PARITY = 5'b01000;
    localparam logic [4:0] ST_STOP = 5'b10000;

    logic [4:0] state;
    logic [4:0] next_state;

    always_ff @(posedge CLK or negedge RST)
    begin
        if (!RST)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    // Next state
    always_comb
    begin
        case (state)
            ST_IDLE:
                next_state = data_valid ? ST_START : ST_IDLE;
            ST_START:
                next_state = ST_DATA;
            ST_DATA:
            begin
                if (ser_done)
                begin
                    next_state = par_en ? ST_PARITY : ST_STOP;
                end
                else
                begin
                    next_state = ST_DATA;
                end
            end
            ST_PARITY:
                next_state = ST_STOP;
            // Always pass through idle, which gives the gap between frames
            ST_STOP:
                next_state = ST_IDLE;
            default:
                next_state = ST_IDLE;
        endcase
    end

    // Outputs decoded from the current state
    always_comb
    begin
        mux_sel = SEL_IDLE_STOP;
        ser_en = 1'b0;
        busy = 1'b1;
        case (state)
            ST_START:
            begin
                mux_sel = SEL_START;
                // Arms the serializer for the first data cycle
                ser_en = 1'b1;
            end
            ST_DATA:
                mux_sel = SEL_DATA;
            ST_PARITY:
                mux_sel = SEL_PARITY;
            ST_STOP:
                mux_sel = SEL_IDLE_STOP;
            default:
                busy = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/uart_tx_serializer.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx_serializer
    import uart_tx_pkg::*;
(
    input  wire                  CLK,
    input  wire                  RST,
    input  wire [DATA_WIDTH-1:0] p_data,
    input  wire                  load,
    input  wire                  ser_en,
    output logic                 ser_data,
    output logic                 ser_done
);

    // Counter value during the last data bit
    localparam logic [CNT_WIDTH-1:0] LAST_CNT = CNT_WIDTH'(DATA_WIDTH - 1);

    logic [DATA_WIDTH-1:0] shreg;
    logic [CNT_WIDTH-1:0]  cnt;
    logic                  active;

    // Byte capture, then shift right once per data cycle
    always_ff @(posedge CLK)
    begin
        if (load)
        begin
            shreg <= p_data;
        end
        else if (active)
        begin
            shreg <= shreg >> 1;
        end
    end

    always_ff @(posedge CLK or negedge RST)
    begin
        if (!RST)
        begin
            active <= 1'b0;
            cnt <= '0;
        end
        else if (ser_en)
        begin
            active <= 1'b1;
            cnt <= '0;
        end
        else if (active)
        begin
            if (ser_done)
            begin
                active <= 1'b0;
                cnt <= '0;
            end
            else
            begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign ser_data = shreg[0];
    assign ser_done = active && (cnt == LAST_CNT);

endmodule

`default_nettype wire

// File: verilog/uart_tx_parity.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx_parity
    import uart_tx_pkg::*;
(
    input  wire                  CLK,
    input  wire                  RST,
    input  wire [DATA_WIDTH-1:0] p_data,
    input  wire                  load,
    input  wire                  par_typ,
    output logic                 par_bit
);

    // Private copy, the serializer register shifts during the frame
    logic [DATA_WIDTH-1:0] data_q;

    always_ff @(posedge CLK or negedge RST)
    begin
        if (!RST)
        begin
            data_q <= '0;
        end
        else if (load)
        begin
            data_q <= p_data;
        end
    end

    // Even parity makes the total count of ones even
    always_comb
    begin
        case (par_typ)
            PAR_EVEN:
                par_bit = ^data_q;
            PAR_ODD:
                par_bit = ~^data_q;
            default:
                par_bit = ^data_q;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/uart_tx_line_driver.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx_line_driver
    import uart_tx_pkg::*;
(
    input  wire       CLK,
    input  wire       RST,
    input  wire [1:0] mux_sel,
    input  wire       ser_data,
    input  wire       par_bit,
    output logic      tx_out
);

    logic line_bit;

    // Bit source for the next bit time
    always_comb
    begin
        case (mux_sel)
            SEL_START:
                line_bit = 1'b0;
            SEL_IDLE_STOP:
                line_bit = 1'b1;
            SEL_DATA:
                line_bit = ser_data;
            SEL_PARITY:
                line_bit = par_bit;
            default:
                line_bit = 1'b1;
        endcase
    end

    // Registered output, line idles high out of reset
    always_ff @(posedge CLK or negedge RST)
    begin
        if (!RST)
        begin
            tx_out <= 1'b1;
        end
        else
        begin
            tx_out <= line_bit;
        end
    end

endmodule

`default_nettype wire

// File: verilog/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx
    import uart_tx_pkg::*;
(
    input  wire                  CLK,
    input  wire                  RST,
    input  wire [DATA_WIDTH-1:0] p_data,
    input  wire                  data_valid,
    input  wire                  par_en,
    input  wire                  par_typ,
    output wire                  tx_out,
    output wire                  busy
);

    wire [1:0] mux_sel;
    wire       ser_en;
    wire       ser_data;
    wire       ser_done;
    wire       par_bit;
    wire       load;

    // Byte accepted only while the sequencer is idle
    assign load = data_valid & ~busy;

    uart_tx_fsm fsm0 (
        .CLK        (CLK),
        .RST        (RST),
        .data_valid (data_valid),
        .par_en     (par_en),
        .ser_done   (ser_done),
        .mux_sel    (mux_sel),
        .ser_en     (ser_en),
        .busy       (busy)
    );

    uart_tx_serializer ser0 (
        .CLK      (CLK),
        .RST      (RST),
        .p_data   (p_data),
        .load     (load),
        .ser_en   (ser_en),
        .ser_data (ser_data),
        .ser_done (ser_done)
    );

    uart_tx_parity par0 (
        .CLK     (CLK),
        .RST     (RST),
        .p_data  (p_data),
        .load    (load),
        .par_typ (par_typ),
        .par_bit (par_bit)
    );

    uart_tx_line_driver drv0 (
        .CLK      (CLK),
        .RST      (RST),
        .mux_sel  (mux_sel),
        .ser_data (ser_data),
        .par_bit  (par_bit),
        .tx_out   (tx_out)
    );

endmodule

`default_nettype wire

// File: testbench/uart_tx_checker.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx_checker
    import uart_tx_pkg::*;
(
    input  wire                  CLK,
    input  wire                  RST,
    input  wire [DATA_WIDTH-1:0] p_data,
    input  wire                  data_valid,
    input  wire                  par_en,
    input  wire                  par_typ,
    input  wire                  tx_out,
    input  wire                  busy,
    output wire [31:0]           error_count,
    output wire [31:0]           accept_count,
    output wire [31:0]           frame_count,
    output wire [31:0]           pending,
    output wire [31:0]           b2b_count
);

    localparam int FRAME_BITS = DATA_WIDTH + 3;

    // Accepted bytes still waiting to show up on the line
    logic [DATA_WIDTH-1:0] q_data[$];
    logic                  q_pen[$];
    logic                  q_ptyp[$];
    int                    q_idx[$];

    int   mon_idx = 0;
    int   cmp_idx = 0;
    int   mon_errors = 0;
    int   cmp_errors = 0;
    int   accepted = 0;
    int   popped = 0;
    int   frames = 0;
    int   b2b = 0;
    int   busy_run = 0;
    int   busy_exp;
    logic busy_pen = 1'b0;

    assign error_count = mon_errors + cmp_errors;
    assign accept_count = accepted;
    assign frame_count = frames;
    assign pending = accepted - popped;
    assign b2b_count = b2b;

    // Line bits of one frame, bit 0 goes out first
    function automatic logic [FRAME_BITS-1:0] expected_frame(
        input logic [DATA_WIDTH-1:0] d,
        input logic                  pen,
        input logic                  ptyp
    );
        logic [FRAME_BITS-1:0] f;
        logic                  p;
        int                    i;
        p = (ptyp == PAR_ODD);
        for (i = 0; i < DATA_WIDTH; i++)
        begin
            p = p ^ d[i];
        end
        f = '0;
        f[DATA_WIDTH:1] = d;
        f[DATA_WIDTH+1] = pen ? p : 1'b1;
        f[DATA_WIDTH+2] = pen;
        return f;
    endfunction

    task next_bit();
        @(negedge CLK);
        cmp_idx = cmp_idx + 1;
    endtask

    // Acceptance and busy watch, sampled mid-cycle
    always @(negedge CLK)
    begin
        mon_idx = mon_idx + 1;
        if (accepted == 0 && (tx_out !== 1'b1 || busy !== 1'b0))
        begin
            $display("error tx_out,busy before first byte expected 2 actual %h", {tx_out, busy});
            mon_errors = mon_errors + 1;
        end
        if (busy)
        begin
            busy_run = busy_run + 1;
        end
        else if (busy_run != 0)
        begin
            busy_exp = busy_pen ? DATA_WIDTH + 3 : DATA_WIDTH + 2;
            if (busy_run != busy_exp)
            begin
                $display("error busy cycles expected %h actual %h", busy_exp, busy_run);
                mon_errors = mon_errors + 1;
            end
            busy_run = 0;
        end
        // Taken at the coming rising edge
        if (RST && data_valid && !busy)
        begin
            q_data.push_back(p_data);
            q_pen.push_back(par_en);
            q_ptyp.push_back(par_typ);
            q_idx.push_back(mon_idx);
            accepted = accepted + 1;
            busy_pen = par_en;
        end
    end

    initial
    begin : compare
        logic                  prev_tx;
        logic                  held;
        logic [DATA_WIDTH-1:0] d;
        logic                  pen;
        logic                  ptyp;
        int                    aidx;
        int                    last_stop;
        int                    len;
        int                    i;
        logic [FRAME_BITS-1:0] exp_f;
        logic [FRAME_BITS-1:0] act_f;
        prev_tx = 1'b1;
        held = 1'b0;
        last_stop = -8;
        forever
        begin
            next_bit();
            if (prev_tx && !tx_out && q_data.size() == 0)
            begin
                $display("a frame started on tx_out with no accepted byte behind it");
                cmp_errors = cmp_errors + 1;
            end
            else if (prev_tx && !tx_out)
            begin
                d = q_data.pop_front();
                pen = q_pen.pop_front();
                ptyp = q_ptyp.pop_front();
                aidx = q_idx.pop_front();
                popped = popped + 1;
                // Start bit lags acceptance by one registered stage
                if (cmp_idx != aidx + 2)
                begin
                    $display("error tx_out start cycle expected %h actual %h", aidx + 2, cmp_idx);
                    cmp_errors = cmp_errors + 1;
                end
                // Byte still offered during the stop bit, next start after one idle bit
                if (held)
                begin
                    b2b = b2b + 1;
                    if (cmp_idx - last_stop - 1 != 1)
                    begin
                        $display("error tx_out idle gap expected 1 actual %h",
                            cmp_idx - last_stop - 1);
                        cmp_errors = cmp_errors + 1;
                    end
                end
                len = pen ? DATA_WIDTH + 3 : DATA_WIDTH + 2;
                exp_f = expected_frame(d, pen, ptyp);
                act_f = '0;
                act_f[0] = tx_out;
                for (i = 1; i < len; i++)
                begin
                    next_bit();
                    act_f[i] = tx_out;
                end
                if (act_f !== exp_f)
                begin
                    $display("error tx_out frame %0d expected %h actual %h", frames, exp_f, act_f);
                    cmp_errors = cmp_errors + 1;
                end
                last_stop = cmp_idx;
                held = data_valid;
                frames = frames + 1;
            end
            prev_tx = tx_out;
        end
    end

endmodule

`default_nettype wire

// File: testbench/uart_tx_tb.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx_tb
    import uart_tx_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int FRAME_COUNT = 64;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_FRAME_CYCLES = 11;
    localparam int MAX_GAP_CYCLES = 8;
    localparam int TIMEOUT_CYCLES =
        RESET_CYCLES + FRAME_COUNT * (MAX_FRAME_CYCLES + MAX_GAP_CYCLES) + 100;
    localparam time DRIVE_DELAY = 10;
    localparam logic [15:0] LFSR_SEED = 16'd40380;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    logic                  CLK;
    logic                  RST;
    logic [DATA_WIDTH-1:0] p_data;
    logic                  data_valid;
    logic                  par_en;
    logic                  par_typ;
    wire                   tx_out;
    wire                   busy;
    wire [31:0]            chk_errors;
    wire [31:0]            chk_accepted;
    wire [31:0]            chk_frames;
    wire [31:0]            chk_pending;
    wire [31:0]            chk_b2b;
    logic [15:0]           lfsr;
    int                    tb_errors;
    int                    cycle_count;
    int                    frame_idx;

    uart_tx dut0 (
        .CLK        (CLK),
        .RST        (RST),
        .p_data     (p_data),
        .data_valid (data_valid),
        .par_en     (par_en),
        .par_typ    (par_typ),
        .tx_out     (tx_out),
        .busy       (busy)
    );

    uart_tx_checker chk0 (
        .CLK          (CLK),
        .RST          (RST),
        .p_data       (p_data),
        .data_valid   (data_valid),
        .par_en       (par_en),
        .par_typ      (par_typ),
        .tx_out       (tx_out),
        .busy         (busy),
        .error_count  (chk_errors),
        .accept_count (chk_accepted),
        .frame_count  (chk_frames),
        .pending      (chk_pending),
        .b2b_count    (chk_b2b)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    function automatic logic [15:0] next_lfsr(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task draw_bits(input int n, output logic [7:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr = next_lfsr(lfsr);
            v = {v[6:0], lfsr[0]};
        end
    endtask

    task send_frame(input int idx);
        logic [7:0] gap_bits;
        logic [7:0] junk;
        logic [7:0] flag_bits;
        logic [7:0] byte_val;
        logic       hold;
        draw_bits(3, gap_bits);
        // Bursts with data_valid held high test back-to-back frames
        hold = (gap_bits[2:0] == 3'd0) || (idx % 16 >= 12);
        while (busy)
        begin
            draw_bits(8, junk);
            draw_bits(2, flag_bits);
            p_data = junk;
            data_valid = hold | (&flag_bits[1:0]);
            @(posedge CLK);
            #DRIVE_DELAY;
        end
        if (!hold)
        begin
            data_valid = 1'b0;
            repeat (gap_bits[2:0]) @(posedge CLK);
            #DRIVE_DELAY;
        end
        draw_bits(8, byte_val);
        draw_bits(2, flag_bits);
        p_data = byte_val;
        par_en = flag_bits[0];
        par_typ = flag_bits[1];
        data_valid = 1'b1;
        @(posedge CLK);
        #DRIVE_DELAY;
    endtask

    task print_counts();
        $display("errors %0d, frames accepted %0d, frames checked %0d",
            tb_errors + chk_errors, chk_accepted, chk_frames);
    endtask

    initial
    begin
        CLK = 1'b0;
        RST = 1'b0;
        p_data = '0;
        data_valid = 1'b0;
        par_en = 1'b0;
        par_typ = PAR_EVEN;
        lfsr = LFSR_SEED;
        tb_errors = 0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #DRIVE_DELAY;
        RST = 1'b1;
        for (frame_idx = 0; frame_idx < FRAME_COUNT; frame_idx++)
        begin
            send_frame(frame_idx);
        end
        data_valid = 1'b0;
        while (chk_frames < FRAME_COUNT) @(posedge CLK);
        repeat (4) @(posedge CLK);
        if (chk_accepted != FRAME_COUNT)
        begin
            $display("the core accepted %0d bytes instead of %0d", chk_accepted, FRAME_COUNT);
            tb_errors = tb_errors + 1;
        end
        if (chk_pending != 0)
        begin
            $display("%0d accepted bytes never appeared on tx_out", chk_pending);
            tb_errors = tb_errors + 1;
        end
        if (chk_b2b == 0)
        begin
            $display("no frame was sent back to back with the one before it");
            tb_errors = tb_errors + 1;
        end
        print_counts();
        if (tb_errors + chk_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge CLK);
            cycle_count = cycle_count + 1;
        end
        $display("run stopped after %0d cycles with frames still outstanding", cycle_count);
        print_counts();
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
verilog/uart_tx_pkg.sv
verilog/uart_tx_fsm.sv
verilog/uart_tx_serializer.sv
verilog/uart_tx_parity.sv
verilog/uart_tx_line_driver.sv
verilog/uart_tx.sv
testbench/uart_tx_checker.sv
testbench/uart_tx_tb.sv
